// File: logic/snake_pkg.sv
package snake_pkg;

	////////////////////
	// Direction encoding
	////////////////////

	// Up increases y, down decreases it
	typedef enum logic [1:0] {
		DIR_RIGHT = 2'd0,
		DIR_UP    = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_DOWN  = 2'd3
	} dir_t;

	////////////////////
	// Grid and body sizes
	////////////////////

	// Both powers of two so coordinates wrap for free
	localparam int GRID_W_DEF = 8;
	localparam int GRID_H_DEF = 8;

	// One segment slot per grid cell
	localparam int MAX_LEN_DEF = GRID_W_DEF * GRID_H_DEF;

	localparam int INIT_LEN = 3; // Head plus two body cells

	// Score counter width
	localparam int SCORE_W = 16;

endpackage

// File: logic/snake_bus_pkg.sv
package snake_bus_pkg;

	// Word addresses on the host bus
	localparam logic [2:0] REG_CTRL   = 3'd0;
	localparam logic [2:0] REG_FOOD   = 3'd1;
	localparam logic [2:0] REG_STATUS = 3'd2;
	localparam logic [2:0] REG_HEAD   = 3'd3;
	localparam logic [2:0] REG_LEN    = 3'd4;

	// Status word bits
	localparam int ST_BUSY = 0;
	localparam int ST_OVER = 1;
	localparam int ST_FOOD = 2;

	// Control word fields
	localparam int CTRL_STEP = 0;
	localparam int CTRL_DIR  = 1; // Two bits, 2:1

	// Coordinate words (food and head) and the length word
	localparam int XY_X = 8;
	localparam int XY_Y = 0;
	localparam int LEN_LSB   = 0;
	localparam int SCORE_LSB = 16;

endpackage

// File: logic/snake_seg_ram.sv
`timescale 1ns/10ps

module snake_seg_ram #(
	parameter int DEPTH = 64,
	parameter int WIDTH = 7
) (
	input  logic                     clk,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] wr_addr,
	input  logic [WIDTH-1:0]         wr_data,
	input  logic [$clog2(DEPTH)-1:0] rd_addr,
	output logic [WIDTH-1:0]         rd_data
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Write port
	always_ff @(posedge clk) begin
		if (we)
			mem[wr_addr] <= wr_data;
	end

	// Registered read, old data on a same address collision
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: logic/snake_host_regs.sv
`timescale 1ns/10ps

module snake_host_regs #(
	parameter int GRID_W = snake_pkg::GRID_W_DEF,
	parameter int GRID_H = snake_pkg::GRID_H_DEF
) (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic                                   wb_cyc,
	input  logic                                   wb_stb,
	input  logic                                   wb_we,
	input  logic [2:0]                             wb_adr,
	input  logic [31:0]                            wb_dat_w,
	output logic [31:0]                            wb_dat_r,
	output logic                                   wb_ack,
	input  logic                                   busy,
	input  logic                                   game_over,
	input  logic [$clog2(GRID_W)-1:0]              head_x,
	input  logic [$clog2(GRID_H)-1:0]              head_y,
	input  logic [$clog2(GRID_W*GRID_H):0]         length,
	input  logic [snake_pkg::SCORE_W-1:0]          score,
	output snake_pkg::dir_t                        dir,
	output logic                                   step_start,
	output logic [$clog2(GRID_W)-1:0]              food_x,
	output logic [$clog2(GRID_H)-1:0]              food_y,
	output logic                                   food_valid,
	input  logic                                   food_eaten
);

	localparam int XW    = $clog2(GRID_W);
	localparam int YW    = $clog2(GRID_H);
	localparam int LEN_W = $clog2(GRID_W*GRID_H) + 1;

	logic        req;     // New transfer not yet acked
	logic        wr_ctrl;
	logic        wr_food;
	logic [31:0] rd_word;

	assign req     = wb_cyc & wb_stb & ~wb_ack;
	assign wr_ctrl = req & wb_we & (wb_adr == snake_bus_pkg::REG_CTRL);
	assign wr_food = req & wb_we & (wb_adr == snake_bus_pkg::REG_FOOD);

	////////////////////
	// Bus handshake and control
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wb_ack     <= 1'b0;
			step_start <= 1'b0;
			dir        <= snake_pkg::DIR_RIGHT;
			food_valid <= 1'b0;
		end else begin
			wb_ack <= req; // Single cycle ack
			// Step only when the walk is idle and the game still runs
			step_start <= wr_ctrl & wb_dat_w[snake_bus_pkg::CTRL_STEP]
				& ~busy & ~game_over;
			if (wr_ctrl)
				dir <= snake_pkg::dir_t'(wb_dat_w[snake_bus_pkg::CTRL_DIR +: 2]);
			if (wr_food)
				food_valid <= 1'b1; // New food wins over an eat
			else if (food_eaten)
				food_valid <= 1'b0;
		end
	end

	// Food position and read data
	always_ff @(posedge clk) begin
		if (wr_food) begin
			food_x <= wb_dat_w[snake_bus_pkg::XY_X +: XW];
			food_y <= wb_dat_w[snake_bus_pkg::XY_Y +: YW];
		end
		if (req)
			wb_dat_r <= rd_word;
	end

	////////////////////
	// Read mux
	////////////////////

	always_comb begin
		rd_word = '0;
		case (wb_adr)
			snake_bus_pkg::REG_CTRL: rd_word[snake_bus_pkg::CTRL_DIR +: 2] = dir;
			snake_bus_pkg::REG_FOOD: begin
				rd_word[snake_bus_pkg::XY_X +: XW] = food_x;
				rd_word[snake_bus_pkg::XY_Y +: YW] = food_y;
			end
			snake_bus_pkg::REG_STATUS: begin
				rd_word[snake_bus_pkg::ST_BUSY] = busy | step_start; // Covers the start gap
				rd_word[snake_bus_pkg::ST_OVER] = game_over;
				rd_word[snake_bus_pkg::ST_FOOD] = food_valid;
			end
			snake_bus_pkg::REG_HEAD: begin
				rd_word[snake_bus_pkg::XY_X +: XW] = head_x;
				rd_word[snake_bus_pkg::XY_Y +: YW] = head_y;
			end
			snake_bus_pkg::REG_LEN: begin
				rd_word[snake_bus_pkg::LEN_LSB +: LEN_W]                = length;
				rd_word[snake_bus_pkg::SCORE_LSB +: snake_pkg::SCORE_W] = score;
			end
			default: rd_word = '0;
		endcase
	end

endmodule

// File: logic/snake_body.sv
`timescale 1ns/10ps

module snake_body #(
	parameter int GRID_W  = snake_pkg::GRID_W_DEF,
	parameter int GRID_H  = snake_pkg::GRID_H_DEF,
	parameter int MAX_LEN = snake_pkg::MAX_LEN_DEF
) (
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         step_start,
	input  snake_pkg::dir_t              dir,
	input  logic [$clog2(MAX_LEN):0]     length,
	output logic [$clog2(GRID_W)-1:0]    head_x,
	output logic [$clog2(GRID_H)-1:0]    head_y,
	output logic [$clog2(GRID_W)-1:0]    tail_x,
	output logic [$clog2(GRID_H)-1:0]    tail_y,
	output logic                         self_col,
	output logic                         step_done,
	output logic                         busy
);

	localparam int XW     = $clog2(GRID_W);
	localparam int YW     = $clog2(GRID_H);
	localparam int ADDR_W = $clog2(MAX_LEN);
	localparam int LEN_W  = ADDR_W + 1;
	localparam int SEG_W  = XW + YW + 1; // {x, y, active}

	localparam logic [XW-1:0]     CENTER_X   = XW'(GRID_W / 2);
	localparam logic [YW-1:0]     CENTER_Y   = YW'(GRID_H / 2);
	localparam logic [SEG_W-1:0]  CENTER_SEG = {CENTER_X, CENTER_Y, 1'b1};
	localparam logic [ADDR_W-1:0] LAST       = ADDR_W'(MAX_LEN - 1);

	logic              init;     // Clearing walk after reset
	logic              walking;
	logic              rd_on;    // Stage 0, address issue
	logic [ADDR_W-1:0] cnt;
	logic              s1_on;    // Stage 1, read data back
	logic [ADDR_W-1:0] s1_idx;
	logic [SEG_W-1:0]  prev_seg; // Entry one below s1_idx
	logic              wr_en;    // Stage 2, write
	logic              wr_last;
	logic [ADDR_W-1:0] wr_addr;
	logic [SEG_W-1:0]  wr_data;
	logic [SEG_W-1:0]  rd_data;
	logic [XW-1:0]     next_x;
	logic [YW-1:0]     next_y;
	logic              seg_active;
	logic [SEG_W-1:0]  new_seg;

	snake_seg_ram #(
		.DEPTH(MAX_LEN),
		.WIDTH(SEG_W)
	) snake_seg_ram_inst (
		.clk    (clk),
		.we     (wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr(cnt),
		.rd_data(rd_data)
	);

	assign busy = init | walking;

	////////////////////
	// Next head, wraps at the edges
	////////////////////

	always_comb begin
		next_x = head_x;
		next_y = head_y;
		case (dir)
			snake_pkg::DIR_RIGHT: next_x = head_x + 1'b1;
			snake_pkg::DIR_UP:    next_y = head_y + 1'b1;
			snake_pkg::DIR_LEFT:  next_x = head_x - 1'b1;
			snake_pkg::DIR_DOWN:  next_y = head_y - 1'b1;
			default:              next_x = head_x;
		endcase
	end

	// Slot i takes old entry i-1, slot 0 the new head
	assign seg_active = (LEN_W'(s1_idx) < length) & prev_seg[0];
	assign new_seg = (s1_idx == '0) ? {head_x, head_y, 1'b1}
		: {prev_seg[SEG_W-1 -: XW], prev_seg[YW:1], seg_active};

	////////////////////
	// Walk control
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			init      <= 1'b1;
			walking   <= 1'b0;
			rd_on     <= 1'b0;
			cnt       <= '0;
			s1_on     <= 1'b0;
			wr_en     <= 1'b0;
			wr_last   <= 1'b0;
			step_done <= 1'b0;
			self_col  <= 1'b0;
			head_x    <= CENTER_X;
			head_y    <= CENTER_Y;
			tail_x    <= CENTER_X;
			tail_y    <= CENTER_Y;
		end else begin
			s1_on     <= rd_on;
			wr_last   <= s1_on & (s1_idx == LAST);
			step_done <= wr_last; // Last write has landed
			if (init) begin
				wr_en <= 1'b1;
				cnt   <= cnt + 1'b1;
				if (cnt == LAST)
					init <= 1'b0;
			end else begin
				wr_en <= s1_on;
				if (step_start && !walking) begin
					walking <= 1'b1;
					rd_on   <= 1'b1;
					cnt     <= '0;
					head_x  <= next_x;
					head_y  <= next_y;
				end else if (rd_on) begin
					cnt <= cnt + 1'b1;
					if (cnt == LAST)
						rd_on <= 1'b0;
				end
				if (step_done)
					walking <= 1'b0;
			end
			// Body segment on the new head
			if (s1_on && s1_idx != '0 && seg_active
				&& prev_seg[SEG_W-1 -: XW] == head_x && prev_seg[YW:1] == head_y)
				self_col <= 1'b1;
			// Highest active slot written ends up as the tail
			if (wr_en && wr_data[0]) begin
				tail_x <= wr_data[SEG_W-1 -: XW];
				tail_y <= wr_data[YW:1];
			end
		end
	end

	// Pipeline payload
	always_ff @(posedge clk) begin
		s1_idx   <= cnt;
		prev_seg <= rd_data;
		if (init) begin
			wr_addr <= cnt;
			wr_data <= (cnt == '0) ? CENTER_SEG : '0;
		end else begin
			wr_addr <= s1_idx;
			wr_data <= new_seg;
		end
	end

endmodule

// File: logic/snake_food.sv
`timescale 1ns/10ps

module snake_food #(
	parameter int GRID_W  = snake_pkg::GRID_W_DEF,
	parameter int GRID_H  = snake_pkg::GRID_H_DEF,
	parameter int MAX_LEN = snake_pkg::MAX_LEN_DEF
) (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          step_done,
	input  logic [$clog2(GRID_W)-1:0]     head_x,
	input  logic [$clog2(GRID_H)-1:0]     head_y,
	input  logic                          self_col,
	input  logic [$clog2(GRID_W)-1:0]     food_x,
	input  logic [$clog2(GRID_H)-1:0]     food_y,
	input  logic                          food_valid,
	output logic                          food_eaten,
	output logic [$clog2(MAX_LEN):0]      length,
	output logic [snake_pkg::SCORE_W-1:0] score,
	output logic                          game_over
);

	localparam int LEN_W = $clog2(MAX_LEN) + 1;

	logic hit;

	assign hit = food_valid & (head_x == food_x) & (head_y == food_y);

	////////////////////
	// Length, score and end of game
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			food_eaten <= 1'b0;
			length     <= LEN_W'(snake_pkg::INIT_LEN);
			score      <= '0;
			game_over  <= 1'b0;
		end else begin
			food_eaten <= 1'b0;
			if (step_done) begin
				if (self_col)
					game_over <= 1'b1; // Sticky until reset
				if (hit) begin
					food_eaten <= 1'b1;
					score      <= score + 1'b1;
					// Growth shows up in the next walk
					if (length != LEN_W'(MAX_LEN))
						length <= length + 1'b1;
				end
			end
		end
	end

endmodule

// File: logic/snake_game.sv
`timescale 1ns/10ps

module snake_game #(
	parameter int GRID_W  = snake_pkg::GRID_W_DEF,
	parameter int GRID_H  = snake_pkg::GRID_H_DEF,
	parameter int MAX_LEN = snake_pkg::MAX_LEN_DEF
) (
	input  logic        clk,
	input  logic        reset,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [2:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack
);

	logic                          busy;
	logic                          game_over;
	logic                          step_start;
	logic                          step_done;
	logic                          self_col;
	snake_pkg::dir_t               dir;
	logic [$clog2(GRID_W)-1:0]     head_x;
	logic [$clog2(GRID_H)-1:0]     head_y;
	logic [$clog2(GRID_W)-1:0]     food_x;
	logic [$clog2(GRID_H)-1:0]     food_y;
	logic                          food_valid;
	logic                          food_eaten;
	logic [$clog2(MAX_LEN):0]      length;
	logic [snake_pkg::SCORE_W-1:0] score;

	////////////////////
	// Host side
	////////////////////

	snake_host_regs #(
		.GRID_W(GRID_W),
		.GRID_H(GRID_H)
	) snake_host_regs_inst (
		.clk       (clk),
		.reset     (reset),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.busy      (busy),
		.game_over (game_over),
		.head_x    (head_x),
		.head_y    (head_y),
		.length    (length),
		.score     (score),
		.dir       (dir),
		.step_start(step_start),
		.food_x    (food_x),
		.food_y    (food_y),
		.food_valid(food_valid),
		.food_eaten(food_eaten)
	);

	////////////////////
	// Game stages
	////////////////////

	snake_body #(
		.GRID_W (GRID_W),
		.GRID_H (GRID_H),
		.MAX_LEN(MAX_LEN)
	) snake_body_inst (
		.clk       (clk),
		.reset     (reset),
		.step_start(step_start),
		.dir       (dir),
		.length    (length),
		.head_x    (head_x),
		.head_y    (head_y),
		.tail_x    (),         // Not needed without a renderer
		.tail_y    (),
		.self_col  (self_col),
		.step_done (step_done),
		.busy      (busy)
	);

	snake_food #(
		.GRID_W (GRID_W),
		.GRID_H (GRID_H),
		.MAX_LEN(MAX_LEN)
	) snake_food_inst (
		.clk       (clk),
		.reset     (reset),
		.step_done (step_done),
		.head_x    (head_x),
		.head_y    (head_y),
		.self_col  (self_col),
		.food_x    (food_x),
		.food_y    (food_y),
		.food_valid(food_valid),
		.food_eaten(food_eaten),
		.length    (length),
		.score     (score),
		.game_over (game_over)
	);

endmodule

// File: dv/snake_properties.sv
`timescale 1ns/10ps

module snake_properties (
	input logic clk,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic busy,
	input logic step_start
);

	int fail_count = 0;

	// Ack only inside a requested transfer
	ack_in_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |-> (wb_cyc && wb_stb))
		else begin
			$error("wb_ack high without wb_cyc and wb_stb");
			fail_count++;
		end

	ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
		wb_ack |=> !wb_ack)
		else begin
			$error("wb_ack high for two cycles in a row");
			fail_count++;
		end

	// No step may start while a walk runs
	step_when_idle: assert property (@(posedge clk) disable iff (reset)
		step_start |-> !busy)
		else begin
			$error("step_start pulsed while the body walk was busy");
			fail_count++;
		end

endmodule

bind snake_host_regs snake_properties snake_properties_inst (
	.clk       (clk),
	.reset     (reset),
	.wb_cyc    (wb_cyc),
	.wb_stb    (wb_stb),
	.wb_ack    (wb_ack),
	.busy      (busy),
	.step_start(step_start)
);

// File: dv/snake_checker.sv
`timescale 1ns/10ps

module snake_checker (
	input  logic        clk,
	input  logic        wb_ack,
	input  logic        wb_we,
	input  logic [2:0]  wb_adr,
	input  logic [31:0] wb_dat_r,
	input  logic        check_en,
	input  int          test_id,
	input  logic [31:0] exp_head,
	input  logic [31:0] exp_len,
	input  logic [31:0] exp_status,
	output int          tests_run,
	output int          tests_failed
);

	localparam int READS_PER_TEST = 3; // Head, length and status

	int   compares;
	int   errors;
	int   cur_id;
	logic en_q;

	initial begin
		tests_run    = 0;
		tests_failed = 0;
		compares     = 0;
		errors       = 0;
		cur_id       = 0;
		en_q         = 1'b0;
	end

	task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("[ERROR] test %0d: %s read 0x%08h, expected 0x%08h", cur_id, name, got, exp);
			errors++;
		end
	endtask

	////////////////////
	// Snoop acked reads, sampled mid cycle
	////////////////////

	always @(negedge clk) begin
		if (check_en)
			cur_id = test_id;
		if (check_en && wb_ack && !wb_we) begin
			compares++;
			case (wb_adr)
				snake_bus_pkg::REG_HEAD:   compare_word("head", wb_dat_r, exp_head);
				snake_bus_pkg::REG_LEN:    compare_word("length/score", wb_dat_r, exp_len);
				snake_bus_pkg::REG_STATUS: compare_word("status", wb_dat_r, exp_status);
				default: begin
					$display("Test %0d: read from unexpected address %0d", cur_id, wb_adr);
					errors++;
				end
			endcase
		end
		// End of a test's read-back
		if (en_q && !check_en) begin
			if (compares != READS_PER_TEST) begin
				$display("Test %0d: saw %0d register reads instead of %0d", cur_id, compares,
					READS_PER_TEST);
				errors++;
			end
			tests_run++;
			if (errors != 0) begin
				tests_failed++;
				$display("Test %0d failed with %0d errors", cur_id, errors);
			end else
				$display("Test %0d passed", cur_id);
			compares = 0;
			errors   = 0;
		end
		en_q = check_en;
	end

endmodule

// File: dv/snake_tb.sv
`timescale 1ns/10ps

module snake_tb;

	localparam int ACK_TIMEOUT  = 20;
	localparam int IDLE_TIMEOUT = 2000;
	localparam int OP_CHECK     = 0; // Read back only
	localparam int OP_STEP      = 1;
	localparam int OP_TWICE     = 2; // Extra step command during the walk
	localparam int LEN0         = snake_pkg::INIT_LEN;

	localparam logic [1:0] RIGHT = snake_pkg::DIR_RIGHT;
	localparam logic [1:0] UP    = snake_pkg::DIR_UP;
	localparam logic [1:0] LEFT  = snake_pkg::DIR_LEFT;
	localparam logic [1:0] DOWN  = snake_pkg::DIR_DOWN;

	logic        clk;
	logic        reset;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [2:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;

	int          cycle;
	logic        hung;
	logic        check_en;
	int          test_id;
	logic [31:0] exp_head;
	logic [31:0] exp_len;
	logic [31:0] exp_status;
	int          tests_run;
	int          tests_failed;

	// Stimulus table columns
	int         row_op[$];
	logic [1:0] row_dir[$];
	logic       row_food[$];
	int         row_fx[$];
	int         row_fy[$];
	int         row_x[$];
	int         row_y[$];
	int         row_len[$];
	int         row_score[$];
	logic       row_over[$];

	snake_game snake_game_inst (
		.clk     (clk),
		.reset   (reset),
		.wb_cyc  (wb_cyc),
		.wb_stb  (wb_stb),
		.wb_we   (wb_we),
		.wb_adr  (wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack  (wb_ack)
	);

	snake_checker snake_checker_inst (
		.clk         (clk),
		.wb_ack      (wb_ack),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_r    (wb_dat_r),
		.check_en    (check_en),
		.test_id     (test_id),
		.exp_head    (exp_head),
		.exp_len     (exp_len),
		.exp_status  (exp_status),
		.tests_run   (tests_run),
		.tests_failed(tests_failed)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	task automatic add_row(input int op, input logic [1:0] dir, input logic food, input int fx,
		input int fy, input int x, input int y, input int len, input int score, input logic over);
		row_op.push_back(op);
		row_dir.push_back(dir);
		row_food.push_back(food);
		row_fx.push_back(fx);
		row_fy.push_back(fy);
		row_x.push_back(x);
		row_y.push_back(y);
		row_len.push_back(len);
		row_score.push_back(score);
		row_over.push_back(over);
	endtask

	////////////////////
	// Test table
	////////////////////

	task automatic build_table();
		// op, dir, food, food x, food y, head x, head y, length, score, game over
		add_row(OP_CHECK, RIGHT, 0, 0, 0, 4, 4, LEN0,     0, 0);
		add_row(OP_STEP,  RIGHT, 0, 0, 0, 5, 4, LEN0,     0, 0);
		add_row(OP_STEP,  RIGHT, 0, 0, 0, 6, 4, LEN0,     0, 0);
		add_row(OP_STEP,  RIGHT, 0, 0, 0, 7, 4, LEN0,     0, 0);
		add_row(OP_STEP,  RIGHT, 0, 0, 0, 0, 4, LEN0,     0, 0); // Wraps to x=0
		add_row(OP_STEP,  UP,    0, 0, 0, 0, 5, LEN0,     0, 0);
		add_row(OP_STEP,  LEFT,  0, 0, 0, 7, 5, LEN0,     0, 0); // Wraps to x=7
		add_row(OP_STEP,  DOWN,  0, 0, 0, 7, 4, LEN0,     0, 0);
		add_row(OP_STEP,  DOWN,  1, 7, 3, 7, 3, LEN0 + 1, 1, 0); // Eats
		add_row(OP_STEP,  LEFT,  1, 2, 2, 6, 3, LEN0 + 1, 1, 0); // Food elsewhere
		add_row(OP_TWICE, LEFT,  0, 0, 0, 5, 3, LEN0 + 1, 1, 0);
		add_row(OP_STEP,  LEFT,  1, 4, 3, 4, 3, LEN0 + 2, 2, 0);
		add_row(OP_STEP,  RIGHT, 0, 0, 0, 5, 3, LEN0 + 2, 2, 1); // Into the neck
		add_row(OP_STEP,  UP,    0, 0, 0, 5, 3, LEN0 + 2, 2, 1);
		add_row(OP_STEP,  DOWN,  0, 0, 0, 5, 3, LEN0 + 2, 2, 1);
	endtask

	function automatic logic [31:0] xy_word(input int x, input int y);
		xy_word = (32'(x) << snake_bus_pkg::XY_X) | (32'(y) << snake_bus_pkg::XY_Y);
	endfunction

	function automatic logic [31:0] ctrl_word(input logic [1:0] dir);
		ctrl_word = (32'(dir) << snake_bus_pkg::CTRL_DIR) | (32'd1 << snake_bus_pkg::CTRL_STEP);
	endfunction

	////////////////////
	// Wishbone master
	////////////////////

	task automatic pause_random();
		int gap;
		gap = $urandom_range(3, 0);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic bus_transfer(input logic we, input logic [2:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waited;
		rdata = '0;
		if (hung)
			return;
		pause_random();
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			@(posedge clk);
			#1;
			waited++;
		end while (!wb_ack && waited < ACK_TIMEOUT);
		if (wb_ack) begin
			rdata = wb_dat_r;
			@(posedge clk); // Hold through the ack cycle
			#1;
		end else begin
			$display("Timeout: no acknowledge from the bus slave within %0d cycles", ACK_TIMEOUT);
			hung = 1'b1;
		end
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		bus_transfer(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
		bus_transfer(1'b0, adr, 32'd0, data);
	endtask

	// Poll status until the walk is over
	task automatic wait_idle();
		logic [31:0] status;
		int          start;
		start  = cycle;
		status = '1;
		while (!hung && status[snake_bus_pkg::ST_BUSY] && cycle - start < IDLE_TIMEOUT)
			wb_read(snake_bus_pkg::REG_STATUS, status);
		if (!hung && status[snake_bus_pkg::ST_BUSY]) begin
			$display("Timeout: game logic still busy after %0d cycles", IDLE_TIMEOUT);
			hung = 1'b1;
		end
	endtask

	initial begin
		logic [31:0] rd;
		logic        food_flag;
		int          prev_score;
		int          assert_fails;
		void'($urandom(10965));
		clk        = 1'b0;
		reset      = 1'b1;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		cycle      = 0;
		hung       = 1'b0;
		check_en   = 1'b0;
		test_id    = 0;
		exp_head   = '0;
		exp_len    = '0;
		exp_status = '0;
		food_flag  = 1'b0;
		prev_score = 0;
		build_table();
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < int'(row_op.size()) && !hung; i++) begin
			test_id = i;
			if (row_food[i]) begin
				wb_write(snake_bus_pkg::REG_FOOD, xy_word(row_fx[i], row_fy[i]));
				food_flag = 1'b1;
			end
			if (row_op[i] != OP_CHECK)
				wb_write(snake_bus_pkg::REG_CTRL, ctrl_word(row_dir[i]));
			if (row_op[i] == OP_TWICE)
				wb_write(snake_bus_pkg::REG_CTRL, ctrl_word(row_dir[i])); // Lands mid walk
			wait_idle();
			if (row_score[i] != prev_score)
				food_flag = 1'b0; // Eaten
			prev_score = row_score[i];
			exp_head   = xy_word(row_x[i], row_y[i]);
			exp_len    = (32'(row_score[i]) << snake_bus_pkg::SCORE_LSB)
				| (32'(row_len[i]) << snake_bus_pkg::LEN_LSB);
			exp_status = (32'(row_over[i]) << snake_bus_pkg::ST_OVER)
				| (32'(food_flag) << snake_bus_pkg::ST_FOOD);
			check_en = 1'b1;
			wb_read(snake_bus_pkg::REG_HEAD, rd);
			wb_read(snake_bus_pkg::REG_LEN, rd);
			wb_read(snake_bus_pkg::REG_STATUS, rd);
			check_en = 1'b0;
			@(posedge clk);
			#1;
		end

		assert_fails = snake_game_inst.snake_host_regs_inst.snake_properties_inst.fail_count;
		if (assert_fails != 0)
			$display("Bus handshake assertions failed %0d times", assert_fails);
		$display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
		if (hung || tests_failed != 0 || tests_run != int'(row_op.size()) || assert_fails != 0)
			$display("RESULT: FAIL");
		else
			$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: snake_game.f
logic/snake_pkg.sv
logic/snake_bus_pkg.sv
logic/snake_seg_ram.sv
logic/snake_host_regs.sv
logic/snake_body.sv
logic/snake_food.sv
logic/snake_game.sv
dv/snake_properties.sv
dv/snake_checker.sv
dv/snake_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the snake game testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module snake_tb -f snake_game.f \
	--Mdir obj_dir -o snake_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/snake_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "Failure reported in $LOG"
	exit 1
fi

echo "Simulation finished without failures"
exit 0
